//--- Bender.yml
package:
  name: csr_index

sources:
  - include_dirs:
      - hw
    files:
      - hw/csr_index_pkg.sv
      - hw/index_push_if.sv
      - hw/index_sequencer.sv
      - hw/request_former.sv
      - hw/request_fifo.sv
      - hw/csr_index_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_csr_index.sv

//--- compile.f
+incdir+hw
hw/csr_index_pkg.sv
hw/index_push_if.sv
hw/index_sequencer.sv
hw/request_former.sv
hw/request_fifo.sv
hw/csr_index_top.sv
verification/tb_csr_index.sv

//--- hw/csr_index_pkg.sv
// ----------------------------------------
// CSR index generator shared types
// ----------------------------------------

`include "csr_index_settings.svh"

package csr_index_pkg;

    // ----------------------------------------
    // Configuration from the host
    // ----------------------------------------
    typedef struct packed {
        logic [`CSR_ADDR_WIDTH-1:0]  array_pointer;
        logic [`CSR_INDEX_WIDTH-1:0] index_start;
        logic [`CSR_INDEX_WIDTH-1:0] index_end;
        logic [`CSR_SHIFT_WIDTH-1:0] shift_amount;
        // 1 shifts left, 0 shifts right
        logic                        shift_left;
    } csr_config_t;

    // ----------------------------------------
    // Memory read request
    // ----------------------------------------
    typedef struct packed {
        logic [`CSR_ADDR_WIDTH-1:0]  base;
        logic [`CSR_INDEX_WIDTH-1:0] offset;
        logic [`CSR_INDEX_WIDTH-1:0] index;
    } mem_request_t;

    // ----------------------------------------
    // Sequencer FSM states
    // ----------------------------------------
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        ACK   = 3'd1,
        BUSY  = 3'd2,
        PAUSE = 3'd3,
        DONE  = 3'd4
    } seq_state_t;

endpackage : csr_index_pkg

//--- hw/csr_index_settings.svh
// ----------------------------------------
// CSR index generator widths and FIFO sizing
// ----------------------------------------

`ifndef CSR_INDEX_SETTINGS_SVH
`define CSR_INDEX_SETTINGS_SVH

// Index and offset width
`define CSR_INDEX_WIDTH 32

// Array pointer width
`define CSR_ADDR_WIDTH 32

// Shift amount, enough for 0..31
`define CSR_SHIFT_WIDTH 5

// Request FIFO entries
`define CSR_FIFO_DEPTH 16

// Fill level where generation pauses
`define CSR_FIFO_PROG_THRESH 8

`endif

//--- hw/csr_index_top.sv
// ----------------------------------------
// CSR edge index generator top level
// ----------------------------------------

`timescale 1ns/100ps

`include "csr_index_settings.svh"

module csr_index_top (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  logic                        config_req,
    input  logic [`CSR_ADDR_WIDTH-1:0]  config_array_pointer,
    input  logic [`CSR_INDEX_WIDTH-1:0] config_index_start,
    input  logic [`CSR_INDEX_WIDTH-1:0] config_index_end,
    input  logic [`CSR_SHIFT_WIDTH-1:0] config_shift_amount,
    input  logic                        config_shift_left,
    input  logic                        request_ready,
    output logic                        config_ack,
    output logic                        request_valid,
    output logic [`CSR_ADDR_WIDTH-1:0]  request_base,
    output logic [`CSR_INDEX_WIDTH-1:0] request_offset,
    output logic [`CSR_INDEX_WIDTH-1:0] request_index,
    output logic                        done
);

    import csr_index_pkg::*;

    csr_config_t                 config_in;
    csr_config_t                 config_run;
    logic                        index_valid;
    logic [`CSR_INDEX_WIDTH-1:0] index;
    logic                        fifo_prog_full;
    mem_request_t                head;

    index_push_if #(.payload_t(mem_request_t)) push_bus ();

    // Pack host fields
    assign config_in.array_pointer = config_array_pointer;
    assign config_in.index_start   = config_index_start;
    assign config_in.index_end     = config_index_end;
    assign config_in.shift_amount  = config_shift_amount;
    assign config_in.shift_left    = config_shift_left;

    index_sequencer i_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_req       (config_req),
        .config_in        (config_in),
        .prog_full        (fifo_prog_full),
        .config_ack       (config_ack),
        .config_out       (config_run),
        .index_valid      (index_valid),
        .index            (index),
        .done             (done)
    );

    request_former i_former (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_run       (config_run),
        .index_valid      (index_valid),
        .index            (index),
        .push             (push_bus.source)
    );

    request_fifo #(.payload_t(mem_request_t)) i_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .pop              (request_valid && request_ready),
        .push             (push_bus.sink),
        .head_valid       (request_valid),
        .head             (head),
        .prog_full        (fifo_prog_full)
    );

    // Unpack FIFO head
    assign request_base   = head.base;
    assign request_offset = head.offset;
    assign request_index  = head.index;

endmodule : csr_index_top

//--- hw/index_push_if.sv
// ----------------------------------------
// Push bus into the request FIFO
// ----------------------------------------

`timescale 1ns/100ps

interface index_push_if #(
    parameter type payload_t = logic
);

    // Write side
    logic     push_valid;
    payload_t push_payload;

    // FIFO fill status back to the writer
    logic     full;
    logic     prog_full;

    modport source (
        output push_valid,
        output push_payload,
        input  full,
        input  prog_full
    );

    modport sink (
        input  push_valid,
        input  push_payload,
        output full,
        output prog_full
    );

endinterface : index_push_if

//--- hw/index_sequencer.sv
// ----------------------------------------
// Index sequencer
// Config handshake, FSM and index counter
// ----------------------------------------

`timescale 1ns/100ps

`include "csr_index_settings.svh"

module index_sequencer (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         config_req,
    input  csr_index_pkg::csr_config_t   config_in,
    input  logic                         prog_full,
    output logic                         config_ack,
    output csr_index_pkg::csr_config_t   config_out,
    output logic                         index_valid,
    output logic [`CSR_INDEX_WIDTH-1:0]  index,
    output logic                         done
);

    import csr_index_pkg::*;

    // ----------------------------------------
    // Wires and registers
    // ----------------------------------------
    seq_state_t                  state;
    seq_state_t                  state_next;
    csr_config_t                 config_q;
    logic [`CSR_INDEX_WIDTH-1:0] count;
    logic                        in_range;
    logic                        last_index;
    logic                        accept_config;
    logic                        load_count;

    // Host request seen while idle
    assign accept_config = (state == IDLE) && config_req;

    // Host dropped its request so counting starts
    assign load_count = (state == ACK) && !config_req;

    // Range checks against the captured end index
    assign in_range   = count < config_q.index_end;
    assign last_index = (count + `CSR_INDEX_WIDTH'(1)) == config_q.index_end;

    // One index per BUSY cycle unless the FIFO is filling up
    assign index_valid = (state == BUSY) && in_range && !prog_full;

    assign index      = count;
    assign config_out = config_q;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (config_req) begin
                    state_next = ACK;
                end
            end
            ACK: begin
                if (!config_req) begin
                    state_next = BUSY;
                end
            end
            BUSY: begin
                // Empty range falls straight through
                if (!in_range) begin
                    state_next = DONE;
                end else if (prog_full) begin
                    state_next = PAUSE;
                end else if (last_index) begin
                    state_next = DONE;
                end
            end
            PAUSE: begin
                if (!prog_full) begin
                    state_next = BUSY;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // Handshake and done flags
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_ack <= 1'b0;
            done       <= 1'b1;
        end else begin
            if (accept_config) begin
                config_ack <= 1'b1;
                done       <= 1'b0;
            end
            if (load_count) begin
                config_ack <= 1'b0;
            end
            // Last push lands in the FIFO during DONE
            if (state == DONE) begin
                done <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Captured config and index counter
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (accept_config) begin
            config_q <= config_in;
        end
        if (load_count) begin
            count <= config_q.index_start;
        end else if (index_valid) begin
            count <= count + `CSR_INDEX_WIDTH'(1);
        end
    end

    // Four-phase rule on the host side
    ack_holds_while_req: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        (config_ack && config_req) |=> config_ack
    );

    // Resume picks up the index held at the pause
    count_held_in_pause: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        (state == PAUSE) |=> $stable(count)
    );

endmodule : index_sequencer

//--- hw/request_fifo.sv
// ----------------------------------------
// Request FIFO
// Show-ahead synchronous FIFO with prog_full
// ----------------------------------------

`timescale 1ns/100ps

`include "csr_index_settings.svh"

module request_fifo #(
    parameter type payload_t = csr_index_pkg::mem_request_t
) (
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  logic       pop,
    index_push_if.sink push,
    output logic       head_valid,
    output payload_t   head,
    output logic       prog_full
);

    localparam int DEPTH   = `CSR_FIFO_DEPTH;
    localparam int THRESH  = `CSR_FIFO_PROG_THRESH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] fill_count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push.push_valid;
    assign do_pop  = pop;

    // Head is read straight from the array
    assign head_valid = fill_count != '0;
    assign head       = mem[rd_ptr];

    // Status from the fill count
    assign push.full      = fill_count == COUNT_W'(DEPTH);
    assign prog_full      = fill_count >= COUNT_W'(THRESH);
    assign push.prog_full = prog_full;

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push.push_payload;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   fill_count <= fill_count + COUNT_W'(1);
                2'b01:   fill_count <= fill_count - COUNT_W'(1);
                default: fill_count <= fill_count;
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        push.push_valid |-> !push.full
    );

    // Top level gates pop with head_valid
    no_pop_when_empty: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        pop |-> head_valid
    );

endmodule : request_fifo

//--- hw/request_former.sv
// ----------------------------------------
// Request former
// Turns each index into a memory request
// ----------------------------------------

`timescale 1ns/100ps

`include "csr_index_settings.svh"

module request_former (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  csr_index_pkg::csr_config_t   config_run,
    input  logic                         index_valid,
    input  logic [`CSR_INDEX_WIDTH-1:0]  index,
    index_push_if.source                 push
);

    import csr_index_pkg::*;

    mem_request_t request_next;

    // ----------------------------------------
    // Address forming
    // ----------------------------------------
    always_comb begin
        request_next.base  = config_run.array_pointer;
        request_next.index = index;
        // Offset kept to 32 bits with overflow dropped
        if (config_run.shift_left) begin
            request_next.offset = index << config_run.shift_amount;
        end else begin
            request_next.offset = index >> config_run.shift_amount;
        end
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push.push_valid <= 1'b0;
        end else begin
            push.push_valid <= index_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        push.push_payload <= request_next;
    end

    // The prog_full pause must keep the FIFO from ever filling
    push_never_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        push.push_valid |-> !push.full
    );

endmodule : request_former

//--- verification/tb_csr_index.sv
// ----------------------------------------
// CSR index generator testbench
// Random configs checked against a queue model
// ----------------------------------------

`timescale 1ns/100ps

`include "csr_index_settings.svh"

module tb_csr_index;

    import csr_index_pkg::*;

    localparam int          NUM_TESTS  = 12;
    localparam int          EMPTY_TEST = 5;
    localparam logic [31:0] SEED       = 32'h99fd_11ea;

    logic ap_clk, areset_generator, config_req, config_shift_left, request_ready;
    logic config_ack, request_valid, done;
    logic [`CSR_ADDR_WIDTH-1:0]  config_array_pointer, request_base;
    logic [`CSR_INDEX_WIDTH-1:0] config_index_start, config_index_end;
    logic [`CSR_INDEX_WIDTH-1:0] request_offset, request_index;
    logic [`CSR_SHIFT_WIDTH-1:0] config_shift_amount;

    logic [31:0]  lfsr_state;
    csr_config_t  tests [NUM_TESTS];
    mem_request_t expected_q [$];
    mem_request_t held_req;
    logic         held_valid, random_ready;
    int           stretch_left, cycle_count, cycle_limit;
    int           error_count, pop_count, failed_tests;

    csr_index_top i_dut (.*);

    always #20 ap_clk = ~ap_clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return value;
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_request(input string name, input mem_request_t expected,
                                 input mem_request_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Expected requests straight from the range and shift rules
    task automatic load_model(input csr_config_t cfg);
        mem_request_t req;
        logic [31:0]  idx;
        logic [31:0]  scale;
        // Offset as a multiply or divide by a power of two
        scale = 32'd1 << cfg.shift_amount;
        for (idx = cfg.index_start; idx < cfg.index_end; idx++) begin
            req.base   = cfg.array_pointer;
            req.index  = idx;
            req.offset = cfg.shift_left ? idx * scale : idx / scale;
            expected_q.push_back(req);
        end
    endtask

    // ----------------------------------------
    // One cycle of ready drive and pop checks
    // ----------------------------------------
    task automatic tick();
        mem_request_t head_now;
        mem_request_t expected;
        seq_state_t   seq_state;
        @(negedge ap_clk);
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            seq_state = i_dut.i_sequencer.state;
            $display("Timeout after %0d cycles, sequencer in %s", cycle_count, seq_state.name());
            $display("=== FAIL ===");
            $finish;
        end else begin
            head_now = '{base: request_base, offset: request_offset, index: request_index};
            if (held_valid && !request_valid) begin
                $display("Error at %0t: request_valid dropped before the pop", $time);
                error_count++;
            end else if (held_valid) begin
                check_request("request_held", held_req, head_now);
            end
            held_valid = 1'b0;
            // Random mode holds each level for 1 to 16 cycles
            if (!random_ready) begin
                request_ready = 1'b1;
            end else begin
                if (stretch_left == 0) begin
                    request_ready = take_bits(1) != 0;
                    stretch_left  = int'(take_bits(4)) + 1;
                end
                stretch_left--;
            end
            // The next rising edge pops with this ready level
            if (request_valid && request_ready) begin
                pop_count++;
                if (expected_q.size() == 0) begin
                    $display("Error at %0t: request popped with none expected", $time);
                    error_count++;
                end else begin
                    expected = expected_q.pop_front();
                    check_request("request", expected, head_now);
                end
            end else if (request_valid) begin
                held_req   = head_now;
                held_valid = 1'b1;
            end
        end
    endtask

    task automatic run_test(input int num, input csr_config_t cfg, input logic random_mode);
        int errors_before;
        int expected_count;
        errors_before = error_count;
        pop_count     = 0;
        random_ready  = random_mode;
        // Open with a stall longer than the FIFO so the pause is reached
        if (random_mode) begin
            request_ready = 1'b0;
            stretch_left  = 2 * `CSR_FIFO_DEPTH;
        end
        load_model(cfg);
        expected_count       = expected_q.size();
        config_array_pointer = cfg.array_pointer;
        config_index_start   = cfg.index_start;
        config_index_end     = cfg.index_end;
        config_shift_amount  = cfg.shift_amount;
        config_shift_left    = cfg.shift_left;
        config_req           = 1'b1;
        tick();
        check_bit("config_ack", 1'b1, config_ack);
        check_bit("done", 1'b0, done);
        repeat (int'(take_bits(2))) begin
            tick();
            check_bit("config_ack", 1'b1, config_ack);
        end
        config_req = 1'b0;
        tick();
        check_bit("config_ack", 1'b0, config_ack);
        check_bit("done", 1'b0, done);
        while (!done) tick();
        while (expected_q.size() != 0 || request_valid) tick();
        if (pop_count != expected_count) begin
            $display("Error: test %0d popped %0d requests, %0d expected",
                     num, pop_count, expected_count);
            error_count++;
        end
        check_bit("done", 1'b1, done);
        if (error_count != errors_before) failed_tests++;
        $display("Test %0d: %0d requests, shift %0d %s, ready %s: %s", num, expected_count,
                 cfg.shift_amount, cfg.shift_left ? "left" : "right",
                 random_mode ? "random" : "high",
                 error_count == errors_before ? "ok" : "errors");
    endtask

    initial begin
        int total_len;
        int len;
        ap_clk = 1'b0;
        areset_generator = 1'b1;
        {config_req, config_shift_left, request_ready} = '0;
        {config_array_pointer, config_index_start, config_index_end} = '0;
        config_shift_amount = '0;
        {held_valid, random_ready} = '0;
        {stretch_left, cycle_count, error_count, pop_count, failed_tests} = '0;
        lfsr_state = SEED;
        total_len  = 0;
        // All configurations drawn up front
        for (int t = 0; t < NUM_TESTS; t++) begin
            len = int'(take_bits(6)) % 41;
            tests[t].array_pointer = take_bits(32);
            tests[t].index_start   = take_bits(31);
            tests[t].shift_amount  = 5'(take_bits(5));
            // First four tests cover both directions in both ready modes
            tests[t].shift_left    = (t < 4) ? (t < 2) : (take_bits(1) != 0);
            if (t == EMPTY_TEST) begin
                len = 0;
                tests[t].index_end = tests[t].index_start >> 1;
            end else begin
                tests[t].index_end = tests[t].index_start + len;
            end
            total_len += len;
        end
        cycle_limit = 4 * total_len + 100 * NUM_TESTS;
        repeat (5) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;
        tick();
        check_bit("config_ack", 1'b0, config_ack);
        check_bit("request_valid", 1'b0, request_valid);
        check_bit("done", 1'b1, done);
        $display("Test reset: %s", error_count == 0 ? "ok" : "errors");
        if (error_count != 0) failed_tests++;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t, tests[t], t % 2 == 1);
        end
        $display("Tests run %0d, failed %0d, check errors %0d",
                 NUM_TESTS + 1, failed_tests, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_csr_index
